// ==== rtl/wave_settings.svh ====
`ifndef WAVE_SETTINGS_SVH
`define WAVE_SETTINGS_SVH

// voices sharing the one rom
`define WAVE_VOICES 8

// position inside a quarter period
`define WAVE_POS_W 20

// rom address, top bits of the position
`define WAVE_ADDR_W 6
`define WAVE_ROM_DEPTH (1 << `WAVE_ADDR_W)

`define WAVE_SAMPLE_W 16

// extra cycles per voice for the rom output to settle
`define WAVE_ROM_CYCLES 3

`endif

// ==== rtl/wave_pkg.sv ====
`include "wave_settings.svh"

package wave_pkg;

    ////////////////////////////////////////////////////////////
    // scalar types
    ////////////////////////////////////////////////////////////

    typedef logic [`WAVE_POS_W-1:0] wave_pos_t;
    typedef logic [`WAVE_POS_W-1:0] wave_step_t;
    typedef logic [1:0] wave_quadrant_t;
    typedef logic [`WAVE_ADDR_W-1:0] rom_addr_t;
    typedef logic signed [`WAVE_SAMPLE_W-1:0] sample_t;
    typedef logic [$clog2(`WAVE_VOICES)-1:0] voice_idx_t;

    // quadrant on top, position below
    typedef struct packed {
        wave_quadrant_t quadrant;
        wave_pos_t      pos;
    } wave_phase_t;

    ////////////////////////////////////////////////////////////
    // per-voice vectors, voice 0 in the low bits
    ////////////////////////////////////////////////////////////

    typedef wave_step_t [`WAVE_VOICES-1:0] step_vec_t;
    typedef wave_phase_t [`WAVE_VOICES-1:0] phase_vec_t;
    typedef sample_t [`WAVE_VOICES-1:0] sample_vec_t;

    typedef enum logic [1:0] {
        seq_idle,
        seq_fetch,
        seq_done
    } seq_state_t;

endpackage

// ==== rtl/phase_accumulator.sv ====
`timescale 1ns/10ps

`include "wave_settings.svh"

module phase_accumulator import wave_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       zero,
    input  logic       advance,
    input  step_vec_t  steps,
    output phase_vec_t phases
);

    localparam wave_pos_t POS_MAX = '1;
    // one rom address step expressed in position units
    localparam wave_pos_t POS_ONE = wave_pos_t'(1) << (`WAVE_POS_W - `WAVE_ADDR_W);

    ////////////////////////////////////////////////////////////
    // fold rule
    ////////////////////////////////////////////////////////////

    function automatic wave_phase_t fold_step(
        input wave_phase_t cur,
        input wave_step_t  step
    );
        wave_phase_t nxt;
        logic        climbing;

        nxt = cur;
        // quadrants 0 and 2 climb, 1 and 3 fall
        climbing = ~cur.quadrant[0];

        if (climbing) begin
            if (step >= POS_MAX - cur.pos) begin
                // mirror off the top
                nxt.pos = POS_MAX - (cur.pos + step + POS_ONE);
                nxt.quadrant = cur.quadrant + 2'd1;
            end else begin
                nxt.pos = cur.pos + step;
            end
        end else begin
            if (step >= cur.pos) begin
                // mirror off zero
                nxt.pos = step + POS_ONE - cur.pos;
                nxt.quadrant = cur.quadrant + 2'd1;
            end else begin
                nxt.pos = cur.pos - step;
            end
        end

        return nxt;
    endfunction

    phase_vec_t next_phases;

    always_comb begin
        for (int v = 0; v < `WAVE_VOICES; v++) begin
            next_phases[v] = fold_step(phases[v], steps[v]);
        end
    end

    ////////////////////////////////////////////////////////////
    // phase registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || zero) begin
            phases <= '0;
        end else if (advance) begin
            phases <= next_phases;
        end
    end

endmodule

// ==== rtl/sine_rom.sv ====
`timescale 1ns/10ps

`include "wave_settings.svh"

module sine_rom import wave_pkg::*; (
    input  logic      clk,
    input  rom_addr_t addr,
    output sample_t   magnitude
);

    // quarter-wave magnitudes, rising from zero
    sample_t rom_mem [0:`WAVE_ROM_DEPTH-1];

    initial begin
        $readmemh("rtl/sine_quarter.hex", rom_mem);
    end

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        magnitude <= rom_mem[addr];
    end

endmodule

// ==== rtl/sample_bank.sv ====
`timescale 1ns/10ps

`include "wave_settings.svh"

module sample_bank import wave_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic           zero,
    input  logic           load,
    input  voice_idx_t     voice,
    input  wave_quadrant_t quadrant,
    input  sample_t        magnitude,
    output sample_vec_t    samples
);

    sample_t signed_sample;

    // second half of the period is negative
    always_comb begin
        if (quadrant[1]) begin
            signed_sample = -magnitude;
        end else begin
            signed_sample = magnitude;
        end
    end

    ////////////////////////////////////////////////////////////
    // sample registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || zero) begin
            samples <= '0;
        end else if (load) begin
            samples[voice] <= signed_sample;
        end
    end

endmodule

// ==== rtl/voice_sequencer.sv ====
`timescale 1ns/10ps

`include "wave_settings.svh"

module voice_sequencer import wave_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       zero,
    input  logic       req,
    output logic       ack,
    output logic       advance,
    output voice_idx_t voice,
    output logic       load
);

    localparam int WAIT_W = $clog2(`WAVE_ROM_CYCLES + 1);
    localparam voice_idx_t LAST_VOICE = voice_idx_t'(`WAVE_VOICES - 1);

    seq_state_t        state;
    logic [WAIT_W-1:0] wait_cnt;
    logic              voice_end;

    // last cycle of this voice's rom wait
    assign voice_end = (wait_cnt == WAIT_W'(`WAVE_ROM_CYCLES));
    assign load = (state == seq_fetch) && voice_end;

    ////////////////////////////////////////////////////////////
    // handshake and voice stepping
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || zero) begin
            state <= seq_idle;
            ack <= 1'b0;
            advance <= 1'b0;
            voice <= '0;
            wait_cnt <= '0;
        end else begin
            advance <= 1'b0;
            case (state)
                seq_idle: begin
                    if (req) begin
                        state <= seq_fetch;
                        advance <= 1'b1;
                        voice <= '0;
                        wait_cnt <= '0;
                    end
                end
                seq_fetch: begin
                    if (voice_end) begin
                        wait_cnt <= '0;
                        if (voice == LAST_VOICE) begin
                            state <= seq_done;
                        end else begin
                            voice <= voice_idx_t'(voice + 1'b1);
                        end
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                seq_done: begin
                    // hold ack until the request is withdrawn
                    if (req) begin
                        ack <= 1'b1;
                    end else begin
                        ack <= 1'b0;
                        state <= seq_idle;
                    end
                end
                default: begin
                    state <= seq_idle;
                end
            endcase
        end
    end

endmodule

// ==== rtl/wave_reader.sv ====
`timescale 1ns/10ps

`include "wave_settings.svh"

module wave_reader import wave_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        zero,
    input  logic        req,
    input  step_vec_t   steps,
    output logic        ack,
    output sample_vec_t samples
);

    logic        advance;
    logic        load;
    voice_idx_t  voice;
    phase_vec_t  phases;
    wave_phase_t cur_phase;
    rom_addr_t   rom_addr;
    sample_t     magnitude;

    // phase of the voice being fetched
    assign cur_phase = phases[voice];
    assign rom_addr = cur_phase.pos[`WAVE_POS_W-1 -: `WAVE_ADDR_W];

    voice_sequencer voice_sequencer_i (
        .clk     (clk),
        .rst     (rst),
        .zero    (zero),
        .req     (req),
        .ack     (ack),
        .advance (advance),
        .voice   (voice),
        .load    (load)
    );

    phase_accumulator phase_accumulator_i (
        .clk     (clk),
        .rst     (rst),
        .zero    (zero),
        .advance (advance),
        .steps   (steps),
        .phases  (phases)
    );

    sine_rom sine_rom_i (
        .clk       (clk),
        .addr      (rom_addr),
        .magnitude (magnitude)
    );

    sample_bank sample_bank_i (
        .clk       (clk),
        .rst       (rst),
        .zero      (zero),
        .load      (load),
        .voice     (voice),
        .quadrant  (cur_phase.quadrant),
        .magnitude (magnitude),
        .samples   (samples)
    );

endmodule

// ==== testbench/wave_reader_assertions.sv ====
`timescale 1ns/10ps

`include "wave_settings.svh"

module wave_reader_assertions import wave_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        zero,
    input logic        req,
    input logic        ack,
    input sample_vec_t samples
);

    int failures;

    initial begin
        failures = 0;
    end

    ////////////////////////////////////////////////////////////
    // handshake rules
    ////////////////////////////////////////////////////////////

    // ack only answers a pending request
    property ack_needs_req;
        @(posedge clk) disable iff (rst || zero)
        $rose(ack) |-> $past(req);
    endproperty

    property samples_hold_under_ack;
        @(posedge clk) disable iff (rst || zero)
        (ack && $past(ack)) |-> $stable(samples);
    endproperty

    // withdrawn request releases ack quickly
    property ack_drops_after_req;
        @(posedge clk) disable iff (rst || zero)
        $fell(req) |-> ##[0:2] !ack;
    endproperty

    assert property (ack_needs_req)
        else begin
            $error("ack rose without a request pending");
            failures++;
        end

    assert property (samples_hold_under_ack)
        else begin
            $error("samples changed while ack was high");
            failures++;
        end

    assert property (ack_drops_after_req)
        else begin
            $error("ack still high two cycles after req fell");
            failures++;
        end

endmodule

// ==== testbench/wave_reader_tb.sv ====
`timescale 1ns/10ps

`include "wave_settings.svh"

module wave_reader_tb import wave_pkg::*; ();

    localparam wave_pos_t POS_TOP = '1;
    localparam wave_pos_t ADDR_UNIT = wave_pos_t'(1) << (`WAVE_POS_W - `WAVE_ADDR_W);
    localparam int ACK_LIMIT = 100;

    logic        clk;
    logic        rst;
    logic        zero;
    logic        req;
    step_vec_t   steps;
    logic        ack;
    sample_vec_t samples;

    // reference model state
    sample_t     table_mem [0:`WAVE_ROM_DEPTH-1];
    wave_phase_t model_phase [0:`WAVE_VOICES-1];
    sample_vec_t expected;
    logic [3:0]  quadrants_seen;

    logic        compare_req;
    int          checks;
    int          errors;
    int          tests;
    int          mark_checks;
    int          mark_errors;

    wave_reader wave_reader_i (
        .clk     (clk),
        .rst     (rst),
        .zero    (zero),
        .req     (req),
        .steps   (steps),
        .ack     (ack),
        .samples (samples)
    );

    bind wave_reader wave_reader_assertions wave_reader_assertions_i (
        .clk     (clk),
        .rst     (rst),
        .zero    (zero),
        .req     (req),
        .ack     (ack),
        .samples (samples)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    initial begin
        $readmemh("rtl/sine_quarter.hex", table_mem);
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // climbing quadrants bounce off the top, falling ones off zero
    function automatic wave_phase_t fold_phase(input wave_phase_t ph, input wave_step_t step);
        wave_phase_t res;
        res = ph;
        if (ph.quadrant == 2'd0 || ph.quadrant == 2'd2) begin
            if (step >= POS_TOP - ph.pos) begin
                res.pos = POS_TOP - wave_pos_t'(ph.pos + step + ADDR_UNIT);
                res.quadrant = ph.quadrant + 2'd1;
            end else begin
                res.pos = ph.pos + step;
            end
        end else begin
            if (step >= ph.pos) begin
                res.pos = wave_pos_t'(step - ph.pos + ADDR_UNIT);
                res.quadrant = ph.quadrant + 2'd1;
            end else begin
                res.pos = ph.pos - step;
            end
        end
        return res;
    endfunction

    function automatic sample_t sample_for_phase(input wave_phase_t ph);
        sample_t mag;
        mag = table_mem[ph.pos[`WAVE_POS_W-1 -: `WAVE_ADDR_W]];
        if (ph.quadrant >= 2'd2) begin
            return -mag;
        end
        return mag;
    endfunction

    task automatic update_model(input step_vec_t s);
        for (int v = 0; v < `WAVE_VOICES; v++) begin
            model_phase[v] = fold_phase(model_phase[v], s[v]);
            expected[v] = sample_for_phase(model_phase[v]);
            quadrants_seen[model_phase[v].quadrant] = 1'b1;
        end
    endtask

    task automatic clear_model();
        for (int v = 0; v < `WAVE_VOICES; v++) begin
            model_phase[v] = '0;
        end
        expected = '0;
    endtask

    ////////////////////////////////////////////////////////////
    // compare process
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (compare_req) begin
            for (int v = 0; v < `WAVE_VOICES; v++) begin
                checks++;
                assert (samples[v] === expected[v]) else begin
                    $display("[FAIL] %0t samples[%0d] expected %0d got %0d",
                             $time, v, expected[v], samples[v]);
                    errors++;
                end
            end
            compare_req = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    task automatic stop_on_timeout(input string what);
        $display("timed out waiting for %s", what);
        $display("Test FAILED");
        $finish;
    endtask

    task automatic wait_for_ack(input logic level);
        int cycles;
        cycles = 0;
        while (ack !== level && cycles < ACK_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (ack !== level) begin
            stop_on_timeout(level ? "ack to rise" : "ack to fall");
        end
    endtask

    task automatic check_samples();
        int cycles;
        cycles = 0;
        compare_req = 1'b1;
        while (compare_req && cycles < 4) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (compare_req) begin
            stop_on_timeout("the sample compare");
        end
    endtask

    task automatic check_ack(input logic level);
        checks++;
        assert (ack === level) else begin
            $display("[FAIL] %0t ack expected %b got %b", $time, level, ack);
            errors++;
        end
    endtask

    task automatic run_round(input step_vec_t s);
        steps = s;
        req = 1'b1;
        wait_for_ack(1'b1);
        update_model(s);
        check_samples();
        req = 1'b0;
        wait_for_ack(1'b0);
    endtask

    task automatic start_test();
        mark_checks = checks;
        mark_errors = errors;
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %0d %s: %0d checks, %0d errors", tests, name,
                 checks - mark_checks, errors - mark_errors);
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        step_vec_t   s;
        sample_vec_t prev;
        void'($urandom(32'h941f));
        rst = 1'b1;
        zero = 1'b0;
        req = 1'b0;
        steps = '0;
        compare_req = 1'b0;
        checks = 0;
        errors = 0;
        tests = 0;
        quadrants_seen = '0;
        clear_model();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        start_test();
        repeat (10) begin
            @(posedge clk);
            #1;
            check_ack(1'b0);
        end
        check_samples();
        report_test("idle after reset");

        // small steps keep every voice inside quadrant 0
        start_test();
        for (int v = 0; v < `WAVE_VOICES; v++) begin
            s[v] = wave_step_t'((v + 1) * 20'h00c00);
        end
        prev = '0;
        for (int r = 0; r < 12; r++) begin
            run_round(s);
            for (int v = 0; v < `WAVE_VOICES; v++) begin
                checks++;
                assert (samples[v] >= prev[v]) else begin
                    $display("[FAIL] %0t samples[%0d] expected at least %0d got %0d",
                             $time, v, prev[v], samples[v]);
                    errors++;
                end
            end
            prev = samples;
        end
        report_test("small fixed steps");

        start_test();
        quadrants_seen = '0;
        for (int r = 0; r < 24; r++) begin
            for (int v = 0; v < `WAVE_VOICES; v++) begin
                s[v] = wave_step_t'($urandom_range(20'h7ffff, 20'h20000));
            end
            run_round(s);
        end
        checks++;
        assert (quadrants_seen == 4'hf) else begin
            $display("random steps did not carry the phases through every quadrant");
            errors++;
        end
        report_test("large random steps");

        // back-pressure, req held long after ack
        start_test();
        steps = s;
        req = 1'b1;
        wait_for_ack(1'b1);
        update_model(s);
        check_samples();
        repeat (40) begin
            @(posedge clk);
            #1;
            check_ack(1'b1);
            check_samples();
        end
        req = 1'b0;
        wait_for_ack(1'b0);
        repeat (5) begin
            @(posedge clk);
            #1;
            check_ack(1'b0);
        end
        run_round(s);
        report_test("held request");

        start_test();
        zero = 1'b1;
        @(posedge clk);
        #1;
        zero = 1'b0;
        clear_model();
        check_samples();
        for (int r = 0; r < 4; r++) begin
            for (int v = 0; v < `WAVE_VOICES; v++) begin
                s[v] = wave_step_t'($urandom_range(20'h7ffff, 20'h20000));
            end
            run_round(s);
        end
        report_test("zero between rounds");

        errors += wave_reader_i.wave_reader_assertions_i.failures;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/sine_quarter.hex ====
// one 16-bit hex magnitude per rom address, quarter sine from 0 upward
0000
0324
0648
096A
0C8C
0FAB
12C8
15E2
18F9
1C0B
1F1A
2223
2528
2826
2B1F
2E11
30FB
33DF
36BA
398C
3C56
3F17
41CE
447A
471C
49B4
4C3F
4EBF
5133
539B
55F5
5842
5A82
5CB3
5ED7
60EB
62F1
64E8
66CF
68A6
6A6D
6C23
6DC9
6F5E
70E2
7254
73B5
7504
7641
776B
7883
7989
7A7C
7B5C
7C29
7CE3
7D89
7E1C
7E9C
7F08
7F61
7FA6
7FD8
7FF5

// ==== project.f ====
+incdir+rtl
rtl/wave_pkg.sv
rtl/phase_accumulator.sv
rtl/sine_rom.sv
rtl/sample_bank.sv
rtl/voice_sequencer.sv
rtl/wave_reader.sv
testbench/wave_reader_assertions.sv
testbench/wave_reader_tb.sv

// ==== Bender.yml ====
package:
  name: wave_reader

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/wave_pkg.sv
      - rtl/phase_accumulator.sv
      - rtl/sine_rom.sv
      - rtl/sample_bank.sv
      - rtl/voice_sequencer.sv
      - rtl/wave_reader.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/wave_reader_assertions.sv
      - testbench/wave_reader_tb.sv
